// File: Bender.yml
package:
  name: l15_shared_port

sources:
  - logic/l15_port_pkg.sv
  - logic/fetch_sequencer.sv
  - logic/mem_req_holder.sv
  - logic/l15_port_arbiter.sv
  - logic/l15_shared_port.sv
  - target: test
    files:
      - testbench/l15_cache_model.sv
      - testbench/tb_l15_shared_port.sv

// File: filelist.f
logic/l15_port_pkg.sv
logic/fetch_sequencer.sv
logic/mem_req_holder.sv
logic/l15_port_arbiter.sv
logic/l15_shared_port.sv
testbench/l15_cache_model.sv
testbench/tb_l15_shared_port.sv

// File: logic/fetch_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_sequencer
	import l15_port_pkg::*;
#(
	parameter logic [addr_w-1:0] reset_pc = '0
)
(
	input  wire                clk,
	input  wire                nrst,

	input  wire                fetch_hold,
	input  wire                fetch_header_ack,
	input  wire                fetch_resp_val,
	input  wire l15_word_t     fetch_resp_data,

	output logic               fetch_val,
	output logic [addr_w-1:0]  fetch_address,

	output logic               instr_val,
	output logic [instr_w-1:0] instr,
	output logic [addr_w-1:0]  instr_pc
);

	logic [addr_w-1:0] pc_q;
	logic              outstanding;
	logic [1:0]        slot;     // 0 idle, 1 low word out, 2 high word out
	l15_word_t         pair_q;
	logic              raise;
	logic              take_resp;

	// Ask again as soon as the second word of a pair leaves
	assign raise = !fetch_hold &&
		((slot == 2'd0 && !outstanding && !fetch_val) || slot == 2'd2);

	assign take_resp = fetch_resp_val && outstanding;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			fetch_val   <= 1'b0;
			outstanding <= 1'b0;
			slot        <= 2'd0;
			pc_q        <= reset_pc;
		end
		else
		begin
			if (fetch_val && fetch_header_ack)
			begin
				fetch_val   <= 1'b0;
				outstanding <= 1'b1;  // Header taken, now wait for data
			end
			else if (raise)
				fetch_val <= 1'b1;

			if (take_resp)
			begin
				outstanding <= 1'b0;
				slot        <= 2'd1;
			end
			else if (slot == 2'd1)
				slot <= 2'd2;
			else if (slot == 2'd2)
			begin
				slot <= 2'd0;
				pc_q <= pc_q + addr_w'(8);  // Next doubleword
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (take_resp)
			pair_q <= fetch_resp_data;
	end

	assign fetch_address = pc_q;

	assign instr_val = (slot != 2'd0);
	assign instr     = pair_q.instr_pair[slot[1]];
	assign instr_pc  = slot[1] ? pc_q + addr_w'(4) : pc_q;

endmodule

`default_nettype wire

// File: logic/l15_port_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module l15_port_arbiter
	import l15_port_pkg::*;
(
	input  wire                  clk,
	input  wire                  nrst,

	// Fetch side
	input  wire                  fetch_val,
	input  wire  [addr_w-1:0]    fetch_address,
	output logic                 fetch_hold,
	output logic                 fetch_header_ack,
	output logic                 fetch_resp_val,

	// Data side
	input  wire                  mem_pending,
	input  wire                  data_val,
	input  wire  [rqtype_w-1:0]  data_rqtype,
	input  wire  [addr_w-1:0]    data_address,
	input  wire  [data_w-1:0]    data_data,
	output logic                 data_header_ack,
	output logic                 data_ack,
	output logic                 data_resp_val,

	// Cache port
	output logic [rqtype_w-1:0]  l15_rqtype,
	output logic [size_w-1:0]    l15_size,
	output logic [addr_w-1:0]    l15_address,
	output logic [data_w-1:0]    l15_data,
	output logic                 l15_val,
	input  wire                  l15_header_ack,
	input  wire                  l15_ack,
	input  wire                  l15_resp_val,
	input  wire  [rettype_w-1:0] l15_resp_returntype,
	output logic                 l15_req_ack
);

	arb_state_t state;
	logic       fetch_out;   // Fetch header taken, response still due

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			state     <= arb_instr;
			fetch_out <= 1'b0;
		end
		else
		begin
			if (fetch_header_ack && fetch_val)
				fetch_out <= 1'b1;
			else if (fetch_resp_val)
				fetch_out <= 1'b0;

			case (state)
				arb_instr:
				begin
					if (mem_pending)
						state <= arb_wait;
				end
				arb_wait:
				begin
					// Leave once the fetch data is back
					if (!fetch_out || fetch_resp_val)
						state <= arb_mem;
				end
				arb_mem:
				begin
					if (!mem_pending)
						state <= arb_instr;
				end
				default:
					state <= arb_instr;
			endcase
		end
	end

	// Request side follows the owner
	always_comb
	begin
		l15_size = size_8b;
		if (state == arb_mem)
		begin
			l15_val     = data_val;
			l15_rqtype  = data_rqtype;
			l15_address = data_address;
			l15_data    = data_data;
		end
		else
		begin
			l15_val     = fetch_val && (state == arb_instr);  // Nothing goes out in arb_wait
			l15_rqtype  = rqtype_ifill;
			l15_address = fetch_address;
			l15_data    = '0;
		end
	end

	assign fetch_hold       = (state != arb_instr) || mem_pending;
	assign fetch_header_ack = l15_header_ack && (state == arb_instr);
	assign data_header_ack  = l15_header_ack && (state == arb_mem);

	// Responses outside arb_mem can only belong to fetch
	assign fetch_resp_val = l15_resp_val && (state != arb_mem);
	assign data_resp_val  = l15_resp_val && (state == arb_mem) &&
		(l15_resp_returntype == rettype_load);
	assign data_ack       = l15_ack && (state == arb_mem);

	assign l15_req_ack = l15_resp_val;

endmodule

`default_nettype wire

// File: logic/l15_port_pkg.sv
`default_nettype none

package l15_port_pkg;

	localparam int addr_w    = 32;
	localparam int data_w    = 64;
	localparam int instr_w   = 32;
	localparam int rqtype_w  = 5;
	localparam int size_w    = 3;
	localparam int rettype_w = 4;

	// Request types as seen by the L1.5
	localparam logic [rqtype_w-1:0] rqtype_load  = 5'b00000;
	localparam logic [rqtype_w-1:0] rqtype_store = 5'b00001;
	localparam logic [rqtype_w-1:0] rqtype_ifill = 5'b10000;

	localparam logic [size_w-1:0] size_4b = 3'b010;
	localparam logic [size_w-1:0] size_8b = 3'b011;

	// Return type of a load response
	localparam logic [rettype_w-1:0] rettype_load = 4'b0000;

	// Port ownership
	typedef enum logic [1:0]
	{
		arb_instr = 2'd0,  // Fetch owns the port
		arb_wait  = 2'd1,  // Draining the fetch response
		arb_mem   = 2'd2   // Data side owns the port
	} arb_state_t;

	// One response word, two readings
	typedef union packed
	{
		logic [1:0][instr_w-1:0] instr_pair;  // Entry 0 is the lower address
		logic [data_w-1:0]       dword;
	} l15_word_t;

endpackage

`default_nettype wire

// File: logic/l15_shared_port.sv
`timescale 1ns/10ps
`default_nettype none

module l15_shared_port
	import l15_port_pkg::*;
#(
	parameter logic [addr_w-1:0] reset_pc = '0
)
(
	input  wire                  clk,
	input  wire                  nrst,

	// Cache port
	output logic [rqtype_w-1:0]  l15_rqtype,
	output logic [size_w-1:0]    l15_size,
	output logic [addr_w-1:0]    l15_address,
	output logic [data_w-1:0]    l15_data,
	output logic                 l15_val,
	input  wire                  l15_header_ack,
	input  wire                  l15_ack,
	input  wire                  l15_resp_val,
	input  wire l15_word_t       l15_resp_data,
	input  wire  [rettype_w-1:0] l15_resp_returntype,
	output logic                 l15_req_ack,

	// Core data strobes
	input  wire                  mem_req,
	input  wire                  mem_store,
	input  wire  [addr_w-1:0]    mem_addr,
	input  wire  [data_w-1:0]    mem_wdata,
	output logic                 mem_busy,
	output logic                 mem_done,
	output logic [data_w-1:0]    mem_rdata,

	// Instruction stream
	output logic                 instr_val,
	output logic [instr_w-1:0]   instr,
	output logic [addr_w-1:0]    instr_pc
);

	logic                fetch_val;
	logic [addr_w-1:0]   fetch_address;
	logic                fetch_hold;
	logic                fetch_header_ack;
	logic                fetch_resp_val;

	logic                mem_pending;
	logic                data_val;
	logic [rqtype_w-1:0] data_rqtype;
	logic [addr_w-1:0]   data_address;
	logic [data_w-1:0]   data_data;
	logic                data_header_ack;
	logic                data_ack;
	logic                data_resp_val;

	fetch_sequencer #(
		.reset_pc         (reset_pc)
	) fetch_sequencer_i (
		.clk              (clk),
		.nrst             (nrst),
		.fetch_hold       (fetch_hold),
		.fetch_header_ack (fetch_header_ack),
		.fetch_resp_val   (fetch_resp_val),
		.fetch_resp_data  (l15_resp_data),
		.fetch_val        (fetch_val),
		.fetch_address    (fetch_address),
		.instr_val        (instr_val),
		.instr            (instr),
		.instr_pc         (instr_pc)
	);

	mem_req_holder mem_req_holder_i (
		.clk             (clk),
		.nrst            (nrst),
		.mem_req         (mem_req),
		.mem_store       (mem_store),
		.mem_addr        (mem_addr),
		.mem_wdata       (mem_wdata),
		.data_header_ack (data_header_ack),
		.data_ack        (data_ack),
		.data_resp_val   (data_resp_val),
		.data_resp_data  (l15_resp_data),  // Same bus as fetch
		.mem_busy        (mem_busy),
		.mem_pending     (mem_pending),
		.data_val        (data_val),
		.data_rqtype     (data_rqtype),
		.data_address    (data_address),
		.data_data       (data_data),
		.mem_done        (mem_done),
		.mem_rdata       (mem_rdata)
	);

	l15_port_arbiter l15_port_arbiter_i (
		.clk                 (clk),
		.nrst                (nrst),
		.fetch_val           (fetch_val),
		.fetch_address       (fetch_address),
		.fetch_hold          (fetch_hold),
		.fetch_header_ack    (fetch_header_ack),
		.fetch_resp_val      (fetch_resp_val),
		.mem_pending         (mem_pending),
		.data_val            (data_val),
		.data_rqtype         (data_rqtype),
		.data_address        (data_address),
		.data_data           (data_data),
		.data_header_ack     (data_header_ack),
		.data_ack            (data_ack),
		.data_resp_val       (data_resp_val),
		.l15_rqtype          (l15_rqtype),
		.l15_size            (l15_size),
		.l15_address         (l15_address),
		.l15_data            (l15_data),
		.l15_val             (l15_val),
		.l15_header_ack      (l15_header_ack),
		.l15_ack             (l15_ack),
		.l15_resp_val        (l15_resp_val),
		.l15_resp_returntype (l15_resp_returntype),
		.l15_req_ack         (l15_req_ack)
	);

endmodule

`default_nettype wire

// File: logic/mem_req_holder.sv
`timescale 1ns/10ps
`default_nettype none

module mem_req_holder
	import l15_port_pkg::*;
(
	input  wire                 clk,
	input  wire                 nrst,

	input  wire                 mem_req,
	input  wire                 mem_store,
	input  wire  [addr_w-1:0]   mem_addr,
	input  wire  [data_w-1:0]   mem_wdata,

	input  wire                 data_header_ack,
	input  wire                 data_ack,
	input  wire                 data_resp_val,
	input  wire l15_word_t      data_resp_data,

	output logic                mem_busy,
	output logic                mem_pending,
	output logic                data_val,
	output logic [rqtype_w-1:0] data_rqtype,
	output logic [addr_w-1:0]   data_address,
	output logic [data_w-1:0]   data_data,
	output logic                mem_done,
	output logic [data_w-1:0]   mem_rdata
);

	logic busy;
	logic sent;      // Header already accepted
	logic is_store;
	logic complete;

	// Store ends on the ack, a load on its response
	assign complete = busy && (is_store ? data_ack : data_resp_val);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			busy     <= 1'b0;
			sent     <= 1'b0;
			is_store <= 1'b0;
			mem_done <= 1'b0;
		end
		else
		begin
			mem_done <= complete;
			if (complete)
				busy <= 1'b0;
			else if (mem_req && !busy)
			begin
				busy     <= 1'b1;
				sent     <= 1'b0;
				is_store <= mem_store;
			end
			else if (data_val && data_header_ack)
				sent <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (mem_req && !busy)
		begin
			data_address <= mem_addr;
			data_data    <= mem_wdata;
		end
		if (complete && !is_store)
			mem_rdata <= data_resp_data.dword;
	end

	assign mem_busy    = busy;
	assign mem_pending = busy && !complete;
	assign data_val    = busy && !sent;
	assign data_rqtype = is_store ? rqtype_store : rqtype_load;

endmodule

`default_nettype wire

// File: testbench/l15_cache_model.sv
`timescale 1ns/10ps
`default_nettype none

module l15_cache_model
	import l15_port_pkg::*;
#(
	parameter int seed_init = 0
)
(
	input  wire                  clk,
	input  wire                  nrst,

	input  wire  [rqtype_w-1:0]  l15_rqtype,
	input  wire  [addr_w-1:0]    l15_address,
	input  wire  [data_w-1:0]    l15_data,
	input  wire                  l15_val,
	output logic                 l15_header_ack,
	output logic                 l15_ack,
	output logic                 l15_resp_val,
	output l15_word_t            l15_resp_data,
	output logic [rettype_w-1:0] l15_resp_returntype
);

	localparam logic [rettype_w-1:0] ret_ifill = 4'b0001;

	integer              seed;
	int                  hold_left;   // Cycles before the header ack, -1 when not counting
	int                  resp_left;
	logic                busy;        // One request accepted and not yet answered
	logic                accepted;
	logic                seen_val;
	logic                in_reset;
	logic [rqtype_w-1:0] req_type;
	logic [addr_w-1:0]   req_addr;
	logic [data_w-1:0]   req_data;
	logic [data_w-1:0]   store_mem [logic [addr_w-1:0]];

	// Unwritten doublewords read back as a mix of the whole address
	function automatic logic [data_w-1:0] load_pattern(input logic [addr_w-1:0] addr);
		return {addr ^ 32'h5a5a_0000, ~addr};
	endfunction

	initial
	begin
		seed                = seed_init;
		hold_left           = -1;
		resp_left           = 0;
		busy                = 1'b0;
		l15_header_ack      = 1'b0;
		l15_ack             = 1'b0;
		l15_resp_val        = 1'b0;
		l15_resp_data       = '0;
		l15_resp_returntype = '0;
		forever
		begin
			@(posedge clk);
			in_reset = !nrst;
			seen_val = l15_val;
			accepted = l15_val && l15_header_ack;
			if (accepted)
			begin
				req_type = l15_rqtype;
				req_addr = l15_address;
				req_data = l15_data;
			end
			#1;
			l15_header_ack = 1'b0;
			l15_ack        = 1'b0;
			l15_resp_val   = 1'b0;
			if (in_reset)
			begin
				busy      = 1'b0;
				hold_left = -1;
			end
			else if (accepted)
			begin
				busy      = 1'b1;
				resp_left = 2 + int'($unsigned($random(seed)) % 4);
				if (req_type == rqtype_store)
					store_mem[req_addr] = req_data;
			end
			else if (busy)
			begin
				resp_left--;
				if (resp_left == 0)
				begin
					busy = 1'b0;
					if (req_type == rqtype_store)
						l15_ack = 1'b1;
					else if (req_type == rqtype_ifill)
					begin
						l15_resp_val                = 1'b1;
						l15_resp_data.instr_pair[0] = req_addr;  // Address in both halves
						l15_resp_data.instr_pair[1] = req_addr;
						l15_resp_returntype         = ret_ifill;
					end
					else
					begin
						l15_resp_val        = 1'b1;
						l15_resp_data.dword = store_mem.exists(req_addr) ?
							store_mem[req_addr] : load_pattern(req_addr);
						l15_resp_returntype = rettype_load;
					end
				end
			end
			else if (seen_val)
			begin
				if (hold_left < 0)
					hold_left = int'($unsigned($random(seed)) % 4);
				if (hold_left == 0)
				begin
					l15_header_ack = 1'b1;
					hold_left      = -1;
				end
				else
					hold_left--;
			end
			else
				hold_left = -1;  // Request withdrawn, start over
		end
	end

endmodule

`default_nettype wire

// File: testbench/tb_l15_shared_port.sv
`timescale 1ns/10ps
`default_nettype none

module tb_l15_shared_port
	import l15_port_pkg::*;
();

	localparam logic [addr_w-1:0] start_pc  = 32'h0000_1000;
	localparam logic [addr_w-1:0] data_base = 32'h0000_8000;
	localparam int num_ops   = 12;
	localparam int seed_init = 32'h5166_022a;
	// Twelve ops need a few hundred cycles, so this leaves a wide margin
	localparam int timeout_cycles = 4000;

	logic                 clk;
	logic                 nrst;
	logic [rqtype_w-1:0]  l15_rqtype;
	logic [size_w-1:0]    l15_size;
	logic [addr_w-1:0]    l15_address;
	logic [data_w-1:0]    l15_data;
	logic                 l15_val;
	logic                 l15_header_ack;
	logic                 l15_ack;
	logic                 l15_resp_val;
	l15_word_t            l15_resp_data;
	logic [rettype_w-1:0] l15_resp_returntype;
	logic                 l15_req_ack;
	logic                 mem_req;
	logic                 mem_store;
	logic [addr_w-1:0]    mem_addr;
	logic [data_w-1:0]    mem_wdata;
	logic                 mem_busy;
	logic                 mem_done;
	logic [data_w-1:0]    mem_rdata;
	logic                 instr_val;
	logic [instr_w-1:0]   instr;
	logic [addr_w-1:0]    instr_pc;

	integer seed;
	int     cycle_count;
	int     fetch_errs = 0;
	int     data_errs  = 0;
	int     port_errs  = 0;

	// Reference state, updated at each rising edge
	logic              nrst_q;
	logic [addr_w-1:0] exp_pc;
	logic              awaiting;    // Accepted request not yet answered
	logic              req_open;    // mem_req still waiting for mem_done
	logic              last_store;
	logic [addr_w-1:0] last_addr;
	logic [data_w-1:0] last_wdata;
	logic [data_w-1:0] exp_rdata;
	logic [data_w-1:0] ref_mem [8];
	logic              ref_valid [8];
	int                done_count;
	int                instr_count;

	l15_shared_port #(
		.reset_pc            (start_pc)
	) l15_shared_port_i (
		.clk                 (clk),
		.nrst                (nrst),
		.l15_rqtype          (l15_rqtype),
		.l15_size            (l15_size),
		.l15_address         (l15_address),
		.l15_data            (l15_data),
		.l15_val             (l15_val),
		.l15_header_ack      (l15_header_ack),
		.l15_ack             (l15_ack),
		.l15_resp_val        (l15_resp_val),
		.l15_resp_data       (l15_resp_data),
		.l15_resp_returntype (l15_resp_returntype),
		.l15_req_ack         (l15_req_ack),
		.mem_req             (mem_req),
		.mem_store           (mem_store),
		.mem_addr            (mem_addr),
		.mem_wdata           (mem_wdata),
		.mem_busy            (mem_busy),
		.mem_done            (mem_done),
		.mem_rdata           (mem_rdata),
		.instr_val           (instr_val),
		.instr               (instr),
		.instr_pc            (instr_pc)
	);

	l15_cache_model #(
		.seed_init           (seed_init)
	) l15_cache_model_i (
		.clk                 (clk),
		.nrst                (nrst),
		.l15_rqtype          (l15_rqtype),
		.l15_address         (l15_address),
		.l15_data            (l15_data),
		.l15_val             (l15_val),
		.l15_header_ack      (l15_header_ack),
		.l15_ack             (l15_ack),
		.l15_resp_val        (l15_resp_val),
		.l15_resp_data       (l15_resp_data),
		.l15_resp_returntype (l15_resp_returntype)
	);

	function automatic logic [data_w-1:0] addr_pattern(input logic [addr_w-1:0] addr);
		return {addr ^ 32'h5a5a_0000, ~addr};
	endfunction

	task automatic show_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] want);
		$display("FAILED %s got 0x%h expected 0x%h at %0t ns", name, got, want, $time);
	endtask

	task automatic show_violation(input string what);
		$display("Error at %0t ns: %s", $time, what);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			nrst_q      <= 1'b0;
			exp_pc      <= start_pc;
			awaiting    <= 1'b0;
			req_open    <= 1'b0;
			done_count  <= 0;
			instr_count <= 0;
			for (int i = 0; i < 8; i++)
				ref_valid[i] <= 1'b0;
		end
		else
		begin
			nrst_q <= 1'b1;
			if (instr_val)
			begin
				exp_pc      <= exp_pc + addr_w'(4);
				instr_count <= instr_count + 1;
			end
			if (l15_val && l15_header_ack)
				awaiting <= 1'b1;
			else if (l15_resp_val || l15_ack)
				awaiting <= 1'b0;
			if (mem_done)
			begin
				req_open   <= 1'b0;
				done_count <= done_count + 1;
			end
			if (mem_req)
			begin
				req_open   <= 1'b1;  // Wins over a done in the same cycle
				last_store <= mem_store;
				last_addr  <= mem_addr;
				last_wdata <= mem_wdata;
				if (mem_store)
				begin
					ref_mem[mem_addr[5:3]]   <= mem_wdata;
					ref_valid[mem_addr[5:3]] <= 1'b1;
				end
				else
					exp_rdata <= ref_valid[mem_addr[5:3]] ?
						ref_mem[mem_addr[5:3]] : addr_pattern(mem_addr);
			end
		end
	end

	assert property (@(posedge clk) (!nrst || !nrst_q) |->
		!(l15_val || instr_val || mem_done || mem_busy))
	else
	begin
		port_errs++;
		show_violation("an output strobe was active during or right after reset");
	end

	// Fetch stream
	assert property (@(posedge clk) disable iff (!nrst) instr_val |-> instr_pc == exp_pc)
	else
	begin
		fetch_errs++;
		show_mismatch("instr_pc", $sampled(instr_pc), $sampled(exp_pc));
	end

	assert property (@(posedge clk) disable iff (!nrst)
		instr_val |-> instr == {exp_pc[addr_w-1:3], 3'b000})
	else
	begin
		fetch_errs++;
		show_mismatch("instr", $sampled(instr), {$sampled(exp_pc[addr_w-1:3]), 3'b000});
	end

	// Cache port protocol
	assert property (@(posedge clk) disable iff (!nrst) awaiting |-> !l15_val)
	else
	begin
		port_errs++;
		show_violation("l15_val raised while an accepted request was still open");
	end

	assert property (@(posedge clk) disable iff (!nrst) l15_resp_val |-> l15_req_ack)
	else
	begin
		port_errs++;
		show_violation("response was not acknowledged with l15_req_ack");
	end

	assert property (@(posedge clk) disable iff (!nrst) l15_val |-> l15_size == size_8b)
	else
	begin
		port_errs++;
		show_mismatch("l15_size", $sampled(l15_size), size_8b);
	end

	assert property (@(posedge clk) disable iff (!nrst)
		l15_val && l15_rqtype != rqtype_ifill |->
		req_open && l15_rqtype == (last_store ? rqtype_store : rqtype_load))
	else
	begin
		port_errs++;
		show_mismatch("l15_rqtype", $sampled(l15_rqtype),
			$sampled(last_store) ? rqtype_store : rqtype_load);
	end

	assert property (@(posedge clk) disable iff (!nrst)
		l15_val && l15_rqtype != rqtype_ifill |-> l15_address == last_addr)
	else
	begin
		port_errs++;
		show_mismatch("l15_address", $sampled(l15_address), $sampled(last_addr));
	end

	assert property (@(posedge clk) disable iff (!nrst)
		l15_val && l15_rqtype != rqtype_ifill |-> l15_data == last_wdata)
	else
	begin
		port_errs++;
		show_mismatch("l15_data", $sampled(l15_data), $sampled(last_wdata));
	end

	// Data side strobes
	assert property (@(posedge clk) disable iff (!nrst) mem_done |-> req_open)
	else
	begin
		data_errs++;
		show_violation("mem_done arrived without an open mem_req");
	end

	assert property (@(posedge clk) disable iff (!nrst) mem_req |-> !req_open || mem_done)
	else
	begin
		data_errs++;
		show_violation("mem_req was issued before the previous mem_done");
	end

	assert property (@(posedge clk) disable iff (!nrst)
		mem_done && !last_store |-> mem_rdata == exp_rdata)
	else
	begin
		data_errs++;
		show_mismatch("mem_rdata", $sampled(mem_rdata), $sampled(exp_rdata));
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		logic [31:0] rnd;
		int          gap;

		seed      = seed_init;
		nrst      = 1'b1;
		mem_req   = 1'b0;
		mem_store = 1'b0;
		mem_addr  = '0;
		mem_wdata = '0;
		#1 nrst = 1'b0;  // Clean falling edge for the async reset
		repeat (10) @(posedge clk);
		#1 nrst = 1'b1;

		for (int op = 0; op < num_ops; op++)
		begin
			gap = int'($unsigned($random(seed)) % 16);
			repeat (gap) next_cycle();
			while (mem_busy)
				next_cycle();
			rnd       = $random(seed);
			mem_req   = 1'b1;
			mem_store = rnd[0];
			mem_addr  = data_base | {26'd0, rnd[6:4], 3'b000};  // Eight doublewords
			mem_wdata = {$random(seed), $random(seed)};
			next_cycle();
			mem_req = 1'b0;
		end
		while (mem_busy)
			next_cycle();
		repeat (40) next_cycle();

		assert (done_count == num_ops && !req_open)
		else
		begin
			data_errs++;
			show_violation("not every mem_req received its mem_done");
		end
		assert (instr_count > 0)
		else
		begin
			fetch_errs++;
			show_violation("no instruction was delivered");
		end

		$display("Errors: fetch %0d, data %0d, port %0d (%0d instructions, %0d memory ops)",
			fetch_errs, data_errs, port_errs, instr_count, done_count);
		if (fetch_errs + data_errs + port_errs == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
